// ==== hw/cpuBusPkg.sv ====
`default_nettype none
//////////////////////////////////////////////////
// CPU bus bridge shared types
// Cycle kinds, sequencer states and bus widths
//////////////////////////////////////////////////

package cpuBusPkg;

    // CPU local bus address, A[20:0]
    localparam int ADDR_WIDTH = 21;

    // Multiplexed DRAM address, row or column
    localparam int CMA_WIDTH = 11;

    // Kind of the cycle opened by tsN
    typedef enum logic [1:0] {
        CYCLE_IDLE = 2'd0,
        CYCLE_RAM  = 2'd1,
        CYCLE_REG  = 2'd2
    } cycleKindE;

    // Chip RAM sequencer
    typedef enum logic [2:0] {
        RAM_IDLE      = 3'd0,
        RAM_ROW       = 3'd1,
        RAM_CAS       = 3'd2,
        RAM_PRECHARGE = 3'd3,
        RAM_DMA       = 3'd4
    } ramStateE;

    // Chipset register cycle
    typedef enum logic [1:0] {
        REG_IDLE      = 2'd0,
        REG_WAITPHASE = 2'd1,
        REG_STROBE    = 2'd2,
        REG_END       = 2'd3
    } regStateE;

endpackage

`default_nettype wire

// ==== hw/cycleDecode.sv ====
`default_nettype none
//////////////////////////////////////////////////
// Cycle decode
// Samples tsN, picks RAM or register cycle and
// latches address, direction and byte lanes
//////////////////////////////////////////////////

module cycleDecode (
    input  wire                                CLK40,
    input  wire                                RESETn,
    input  wire                                tsN,
    input  wire                                rnw,
    input  wire                                ramSpaceN,
    input  wire                                regSpaceN,
    input  wire  [1:0]                         siz,
    input  wire  [cpuBusPkg::ADDR_WIDTH-1:0]   a,
    input  wire                                cycleDone,
    output logic                               ramStart,
    output logic                               regStart,
    output logic                               writeQ,
    output logic [cpuBusPkg::ADDR_WIDTH-1:0]   addrQ,
    output logic [3:0]                         laneEn
);

    cpuBusPkg::cycleKindE kind;
    logic [3:0]           laneNext;
    logic                 tsValid;

    // Transfer start only counts with a space selected
    // and no cycle already open
    assign tsValid = !tsN && (!ramSpaceN || !regSpaceN)
                     && (kind == cpuBusPkg::CYCLE_IDLE);

    ////////////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////////////

    // Lanes UU UM LM LL in bits 3..0
    always_comb begin
        case (siz)
            // Byte, one lane picked by A1:A0
            2'b01:   laneNext = 4'b1000 >> a[1:0];
            // Word, upper or lower half by A1
            2'b10:   laneNext = a[1] ? 4'b0011 : 4'b1100;
            // Long and line use all four
            default: laneNext = 4'b1111;
        endcase
    end

    ////////////////////////////////////////////////
    // Cycle control
    ////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            kind     <= cpuBusPkg::CYCLE_IDLE;
            ramStart <= 1'b0;
            regStart <= 1'b0;
            laneEn   <= 4'b0000;
        end else begin
            // One clock start pulses
            ramStart <= tsValid && !ramSpaceN;
            regStart <= tsValid && ramSpaceN;
            if (tsValid) begin
                kind   <= !ramSpaceN ? cpuBusPkg::CYCLE_RAM : cpuBusPkg::CYCLE_REG;
                laneEn <= laneNext;
            end else if (cycleDone) begin
                // Lanes drop with the acknowledge
                kind   <= cpuBusPkg::CYCLE_IDLE;
                laneEn <= 4'b0000;
            end
        end
    end

    // Address and direction held for the whole cycle
    always_ff @(posedge CLK40) begin
        if (tsValid) begin
            addrQ  <= a;
            writeQ <= !rnw;
        end
    end

    // CPU waits for tackN before the next start
    tsWhileOpen: assert property (@(posedge CLK40) disable iff (!RESETn)
        (kind != cpuBusPkg::CYCLE_IDLE) |-> tsN)
        else $error("tsN asserted while a cycle is open");

endmodule

`default_nettype wire

// ==== hw/chipRamCycle.sv ====
`default_nettype none
//////////////////////////////////////////////////
// Chip RAM cycle
// RAS/CAS sequencer for CPU cycles, with DMA
// arbitration and chipset strobe pass-through
//////////////////////////////////////////////////

module chipRamCycle #(
    parameter int RAS_TO_CAS = 2,
    parameter int CAS_WIDTH  = 2
) (
    input  wire                                CLK40,
    input  wire                                RESETn,
    input  wire                                ramStart,
    input  wire                                writeQ,
    input  wire  [cpuBusPkg::ADDR_WIDTH-1:0]   addrQ,
    input  wire                                dbrN,
    input  wire                                ras0N,
    input  wire                                casLN,
    input  wire                                casUN,
    input  wire                                aweN,
    input  wire  [9:0]                         dra,
    output logic                               rasN,
    output logic                               casN,
    output logic                               weN,
    output logic [cpuBusPkg::CMA_WIDTH-1:0]    cma,
    output logic                               cpuRamActive,
    output logic                               ramDone
);

    localparam int CNT_W = $clog2(RAS_TO_CAS + CAS_WIDTH + 1);

    cpuBusPkg::ramStateE              state;
    logic [CNT_W-1:0]                 waitCnt;
    logic [1:0]                       dbrSync;
    logic                             dbrQ;
    logic                             pending;
    logic                             startReq;
    logic [cpuBusPkg::CMA_WIDTH-1:0]  rowAddr;
    logic [cpuBusPkg::CMA_WIDTH-1:0]  colAddr;

    ////////////////////////////////////////////////
    // dbrN synchronizer
    ////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            dbrSync <= 2'b11;
        end else begin
            dbrSync <= {dbrSync[0], dbrN};
        end
    end

    assign dbrQ     = dbrSync[1];
    // Start held over while the chipset owns the DRAM
    assign startReq = ramStart || pending;

    // Row A20..A10, column A9..A2
    assign rowAddr = addrQ[cpuBusPkg::ADDR_WIDTH-1 -: cpuBusPkg::CMA_WIDTH];
    assign colAddr = {{(cpuBusPkg::CMA_WIDTH - 8){1'b0}}, addrQ[9:2]};

    ////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state   <= cpuBusPkg::RAM_IDLE;
            waitCnt <= '0;
            pending <= 1'b0;
        end else begin
            case (state)
                cpuBusPkg::RAM_IDLE, cpuBusPkg::RAM_DMA: begin
                    if (!dbrQ) begin
                        // DMA wins between CPU cycles
                        state   <= cpuBusPkg::RAM_DMA;
                        pending <= startReq;
                    end else if (startReq) begin
                        state   <= cpuBusPkg::RAM_ROW;
                        waitCnt <= CNT_W'(RAS_TO_CAS - 1);
                        pending <= 1'b0;
                    end else begin
                        state <= cpuBusPkg::RAM_IDLE;
                    end
                end
                cpuBusPkg::RAM_ROW: begin
                    // RAS to CAS delay
                    if (waitCnt == '0) begin
                        state   <= cpuBusPkg::RAM_CAS;
                        waitCnt <= CNT_W'(CAS_WIDTH - 1);
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                cpuBusPkg::RAM_CAS: begin
                    if (waitCnt == '0) begin
                        state <= cpuBusPkg::RAM_PRECHARGE;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                // Pending DMA is picked up from idle
                default: state <= cpuBusPkg::RAM_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////
    // DRAM pins
    ////////////////////////////////////////////////

    always_comb begin
        rasN = 1'b1;
        casN = 1'b1;
        weN  = 1'b1;
        cma  = '0;
        case (state)
            cpuBusPkg::RAM_ROW: begin
                rasN = 1'b0;
                cma  = rowAddr;
            end
            cpuBusPkg::RAM_CAS: begin
                rasN = 1'b0;
                casN = 1'b0;
                weN  = !writeQ;
                cma  = colAddr;
            end
            cpuBusPkg::RAM_PRECHARGE: cma = colAddr;
            cpuBusPkg::RAM_DMA: begin
                // Chipset strobes straight through
                rasN = ras0N;
                casN = casLN && casUN;
                weN  = aweN;
                cma  = {1'b0, dra};
            end
            default: ;
        endcase
    end

    assign cpuRamActive = (state == cpuBusPkg::RAM_ROW) || (state == cpuBusPkg::RAM_CAS)
                          || (state == cpuBusPkg::RAM_PRECHARGE);
    // RAS and CAS rise together with done
    assign ramDone = (state == cpuBusPkg::RAM_PRECHARGE);

    // CPU CAS only under a RAS already open the clock before
    casUnderRas: assert property (@(posedge CLK40) disable iff (!RESETn)
        (state != cpuBusPkg::RAM_DMA && !casN) |-> (!rasN && $past(!rasN)))
        else $error("casN low without rasN held low");

endmodule

`default_nettype wire

// ==== hw/regCycle.sv ====
`default_nettype none
//////////////////////////////////////////////////
// Register cycle
// 16 bit chipset access with AS and data strobes
// aligned to the c1/c3 phase
//////////////////////////////////////////////////

module regCycle #(
    parameter int REG_HOLD = 6
) (
    input  wire         CLK40,
    input  wire         RESETn,
    input  wire         regStart,
    input  wire         c1,
    input  wire         c3,
    input  wire         a1,
    input  wire  [3:0]  laneEn,
    output logic        asN,
    output logic        udsN,
    output logic        ldsN,
    output logic        regEnN,
    output logic        regDone
);

    localparam int CNT_W = $clog2(REG_HOLD + 1);

    cpuBusPkg::regStateE state;
    logic [CNT_W-1:0]    holdCnt;
    logic [1:0]          halfLanes;
    logic                strobe;

    // A1 picks the 16 bit half, upper byte in bit 1
    assign halfLanes = a1 ? laneEn[1:0] : laneEn[3:2];
    assign strobe    = (state == cpuBusPkg::REG_STROBE);

    ////////////////////////////////////////////////
    // Phase FSM
    ////////////////////////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state   <= cpuBusPkg::REG_IDLE;
            holdCnt <= '0;
        end else begin
            case (state)
                cpuBusPkg::REG_IDLE: begin
                    if (regStart) begin
                        state <= cpuBusPkg::REG_WAITPHASE;
                    end
                end
                cpuBusPkg::REG_WAITPHASE: begin
                    // Chipset slot opens on c1 high, c3 low
                    if (c1 && !c3) begin
                        state   <= cpuBusPkg::REG_STROBE;
                        holdCnt <= CNT_W'(REG_HOLD - 1);
                    end
                end
                cpuBusPkg::REG_STROBE: begin
                    if (holdCnt == '0) begin
                        state <= cpuBusPkg::REG_END;
                    end else begin
                        holdCnt <= holdCnt - 1'b1;
                    end
                end
                default: state <= cpuBusPkg::REG_IDLE;
            endcase
        end
    end

    // Strobes low for the hold window only
    assign asN     = !strobe;
    assign regEnN  = !strobe;
    assign udsN    = !(strobe && halfLanes[1]);
    assign ldsN    = !(strobe && halfLanes[0]);
    // Done on the clock the strobes rise
    assign regDone = (state == cpuBusPkg::REG_END);

    // AS opens only out of a matched phase
    asOnPhase: assert property (@(posedge CLK40) disable iff (!RESETn)
        $fell(asN) |-> $past(state == cpuBusPkg::REG_WAITPHASE && c1 && !c3))
        else $error("asN fell outside the c1/c3 slot");

endmodule

`default_nettype wire

// ==== hw/busResult.sv ====
`default_nettype none
//////////////////////////////////////////////////
// Bus result
// Cycle acknowledge, data buffer control and
// byte enables toward chip RAM and CPU
//////////////////////////////////////////////////

module busResult (
    input  wire         CLK40,
    input  wire         RESETn,
    input  wire         ramDone,
    input  wire         regDone,
    input  wire         cpuRamActive,
    input  wire         writeQ,
    input  wire  [3:0]  laneEn,
    output logic        tackN,
    output logic        cycleDone,
    output logic        dbenN,
    output logic        dbDir,
    output logic        cuubeN,
    output logic        cumbeN,
    output logic        clmbeN,
    output logic        cllbeN,
    output logic        uubeN,
    output logic        umbeN,
    output logic        lmbeN,
    output logic        llbeN
);

    // Either cycle ends the CPU transfer
    assign cycleDone = ramDone || regDone;

    // One clock acknowledge after done
    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            tackN <= 1'b1;
        end else begin
            tackN <= !cycleDone;
        end
    end

    // Buffer opens for the CPU RAM window, high toward RAM on writes
    assign dbenN = !cpuRamActive;
    assign dbDir = cpuRamActive && writeQ;

    // Chip side lanes only while the CPU owns the DRAM
    assign {cuubeN, cumbeN, clmbeN, cllbeN} = ~(laneEn & {4{cpuRamActive}});
    // CPU side lanes held for the whole cycle
    assign {uubeN, umbeN, lmbeN, llbeN} = ~laneEn;

    singleTack: assert property (@(posedge CLK40) disable iff (!RESETn)
        !tackN |=> tackN)
        else $error("tackN low for more than one clock");

endmodule

`default_nettype wire

// ==== hw/u712Bridge.sv ====
`default_nettype none
//////////////////////////////////////////////////
// U712 bridge top
// CPU local bus to chip RAM and chipset registers
//////////////////////////////////////////////////

module u712Bridge #(
    parameter int RAS_TO_CAS = 2,
    parameter int CAS_WIDTH  = 2,
    parameter int REG_HOLD   = 6
) (
    input  wire                                CLK40,
    input  wire                                RESETn,
    // CPU local bus
    input  wire                                tsN,
    input  wire                                rnw,
    input  wire                                ramSpaceN,
    input  wire                                regSpaceN,
    input  wire  [1:0]                         siz,
    input  wire  [cpuBusPkg::ADDR_WIDTH-1:0]   a,
    output logic                               tackN,
    // Chipset side
    input  wire                                c1,
    input  wire                                c3,
    input  wire                                dbrN,
    input  wire                                ras0N,
    input  wire                                casLN,
    input  wire                                casUN,
    input  wire                                aweN,
    input  wire  [9:0]                         dra,
    output logic                               rasN,
    output logic                               casN,
    output logic                               weN,
    output logic [cpuBusPkg::CMA_WIDTH-1:0]    cma,
    output logic                               asN,
    output logic                               udsN,
    output logic                               ldsN,
    output logic                               regEnN,
    // Data buffers and byte enables
    output logic                               dbenN,
    output logic                               dbDir,
    output logic                               cuubeN,
    output logic                               cumbeN,
    output logic                               clmbeN,
    output logic                               cllbeN,
    output logic                               uubeN,
    output logic                               umbeN,
    output logic                               lmbeN,
    output logic                               llbeN
);

    logic                              ramStart;
    logic                              regStart;
    logic                              writeQ;
    logic [cpuBusPkg::ADDR_WIDTH-1:0]  addrQ;
    logic [3:0]                        laneEn;
    logic                              ramDone;
    logic                              regDone;
    logic                              cycleDone;
    logic                              cpuRamActive;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    cycleDecode u_cycleDecode (
        .CLK40     (CLK40),
        .RESETn    (RESETn),
        .tsN       (tsN),
        .rnw       (rnw),
        .ramSpaceN (ramSpaceN),
        .regSpaceN (regSpaceN),
        .siz       (siz),
        .a         (a),
        .cycleDone (cycleDone),
        .ramStart  (ramStart),
        .regStart  (regStart),
        .writeQ    (writeQ),
        .addrQ     (addrQ),
        .laneEn    (laneEn)
    );

    //////////////////////////////////////////////////
    // Chip RAM and DMA
    //////////////////////////////////////////////////

    chipRamCycle #(
        .RAS_TO_CAS (RAS_TO_CAS),
        .CAS_WIDTH  (CAS_WIDTH)
    ) u_chipRamCycle (
        .CLK40        (CLK40),
        .RESETn       (RESETn),
        .ramStart     (ramStart),
        .writeQ       (writeQ),
        .addrQ        (addrQ),
        .dbrN         (dbrN),
        .ras0N        (ras0N),
        .casLN        (casLN),
        .casUN        (casUN),
        .aweN         (aweN),
        .dra          (dra),
        .rasN         (rasN),
        .casN         (casN),
        .weN          (weN),
        .cma          (cma),
        .cpuRamActive (cpuRamActive),
        .ramDone      (ramDone)
    );

    //////////////////////////////////////////////////
    // Chipset registers
    //////////////////////////////////////////////////

    regCycle #(
        .REG_HOLD (REG_HOLD)
    ) u_regCycle (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .regStart (regStart),
        .c1       (c1),
        .c3       (c3),
        .a1       (addrQ[1]),
        .laneEn   (laneEn),
        .asN      (asN),
        .udsN     (udsN),
        .ldsN     (ldsN),
        .regEnN   (regEnN),
        .regDone  (regDone)
    );

    //////////////////////////////////////////////////
    // Termination and buffers
    //////////////////////////////////////////////////

    busResult u_busResult (
        .CLK40        (CLK40),
        .RESETn       (RESETn),
        .ramDone      (ramDone),
        .regDone      (regDone),
        .cpuRamActive (cpuRamActive),
        .writeQ       (writeQ),
        .laneEn       (laneEn),
        .tackN        (tackN),
        .cycleDone    (cycleDone),
        .dbenN        (dbenN),
        .dbDir        (dbDir),
        .cuubeN       (cuubeN),
        .cumbeN       (cumbeN),
        .clmbeN       (clmbeN),
        .cllbeN       (cllbeN),
        .uubeN        (uubeN),
        .umbeN        (umbeN),
        .lmbeN        (lmbeN),
        .llbeN        (llbeN)
    );

endmodule

`default_nettype wire

// ==== verif/u712BridgeTb.sv ====
`default_nettype none
//////////////////////////////////////////////////
// U712 bridge testbench
// RAM, register and DMA traffic checked by
// concurrent assertions on the bus timing
//////////////////////////////////////////////////

module u712BridgeTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAS_TO_CAS = 2;
    localparam int CAS_WIDTH  = 2;
    localparam int REG_HOLD   = 6;
    localparam int ACK_LIMIT  = 60;
    // Strobes and enables high with dbDir low
    localparam logic [17:0] RESET_CTRL = 18'h3fffe;

    logic        CLK40;
    logic        RESETn;
    logic        tsN;
    logic        rnw;
    logic        ramSpaceN;
    logic        regSpaceN;
    logic [1:0]  siz;
    logic [20:0] a;
    logic        c1 = 1'b0;
    logic        c3 = 1'b0;
    logic        dbrN;
    logic        ras0N;
    logic        casLN;
    logic        casUN;
    logic        aweN;
    logic [9:0]  dra;
    logic        tackN;
    logic        rasN;
    logic        casN;
    logic        weN;
    logic [10:0] cma;
    logic        asN;
    logic        udsN;
    logic        ldsN;
    logic        regEnN;
    logic        dbenN;
    logic        dbDir;
    logic        cuubeN;
    logic        cumbeN;
    logic        clmbeN;
    logic        cllbeN;
    logic        uubeN;
    logic        umbeN;
    logic        lmbeN;
    logic        llbeN;

    // Expected cycle attributes latched with tsN
    logic [3:0]  expLane;
    logic [10:0] expRow;
    logic [10:0] expCol;
    logic        expWrite;
    logic        expA1;
    // Low while CPU cycles may be held off by DMA
    logic        directRun;
    logic [1:0]  phaseCnt = 2'd0;
    int          seed = 32'hefd6;
    int          valueErrors = 0;
    int          otherErrors = 0;

    logic [17:0] ctrlVec;
    logic [14:0] dmaExpect;
    logic [14:0] dmaActual;

    assign ctrlVec   = {tackN, rasN, casN, weN, asN, udsN, ldsN, regEnN, dbenN,
                        cuubeN, cumbeN, clmbeN, cllbeN, uubeN, umbeN, lmbeN, llbeN, dbDir};
    // Buffer closed and CAS low when either chipset CAS is low
    assign dmaExpect = {1'b1, ras0N, !(!casLN || !casUN), aweN, 1'b0, dra};
    assign dmaActual = {dbenN, rasN, casN, weN, cma};

    u712Bridge #(
        .RAS_TO_CAS (RAS_TO_CAS),
        .CAS_WIDTH  (CAS_WIDTH),
        .REG_HOLD   (REG_HOLD)
    ) u_dut (.*);

    initial begin
        CLK40 = 1'b0;
        forever #10 CLK40 = ~CLK40;
    end

    // Chipset phase with c1 high and c3 low on one clock of four
    always @(posedge CLK40) begin
        phaseCnt <= phaseCnt + 2'd1;
        c1       <= phaseCnt[1];
        c3       <= phaseCnt[1] ^ phaseCnt[0];
    end

    //////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////

    // Lanes UU UM LM LL with UU in bit 3
    function automatic logic [3:0] laneMask(input logic [1:0] s, input logic [1:0] lowA);
        logic [3:0] lanes;
        lanes = 4'b1111;
        if (s == 2'b01) begin
            case (lowA)
                2'd0:    lanes = 4'b1000;
                2'd1:    lanes = 4'b0100;
                2'd2:    lanes = 4'b0010;
                default: lanes = 4'b0001;
            endcase
        end else if (s == 2'b10) begin
            lanes = lowA[1] ? 4'b0011 : 4'b1100;
        end
        return lanes;
    endfunction

    // Upper and lower byte of the half picked by A1
    function automatic logic [1:0] strobeMask(input logic [3:0] lanes, input logic a1);
        logic upper;
        logic lower;
        if (!a1) begin
            upper = lanes[3];
            lower = lanes[2];
        end else begin
            upper = lanes[1];
            lower = lanes[0];
        end
        return {upper, lower};
    endfunction

    task automatic reportValue(input string testName, input logic [31:0] expVal,
                               input logic [31:0] actVal);
        valueErrors++;
        $display("** Error %s: expected %0h, actual %0h", testName, expVal, actVal);
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    resetValues: assert property (@(posedge CLK40) ($past(!RESETn) && RESETn)
        |-> ctrlVec == RESET_CTRL)
        else reportValue("reset values", 32'(RESET_CTRL), 32'($sampled(ctrlVec)));

    // Chip and CPU side lanes during the CPU RAM window
    laneRule: assert property (@(posedge CLK40) disable iff (!RESETn)
        !dbenN |-> {cuubeN, cumbeN, clmbeN, cllbeN, uubeN, umbeN, lmbeN, llbeN}
                   == {~expLane, ~expLane})
        else reportValue("byte lanes", 32'({~expLane, ~expLane}),
            32'($sampled({cuubeN, cumbeN, clmbeN, cllbeN, uubeN, umbeN, lmbeN, llbeN})));

    // Buffer enabled whenever a CPU cycle holds RAS
    bufferEnable: assert property (@(posedge CLK40) disable iff (!RESETn)
        (!rasN && directRun) |-> !dbenN)
        else reportValue("buffer enable", 32'd0, 32'($sampled(dbenN)));

    bufferDir: assert property (@(posedge CLK40) disable iff (!RESETn)
        !dbenN |-> dbDir == expWrite)
        else reportValue("buffer direction", 32'(expWrite), 32'($sampled(dbDir)));

    rowAddress: assert property (@(posedge CLK40) disable iff (!RESETn)
        ($fell(rasN) && !dbenN) |-> cma == expRow)
        else reportValue("row address", 32'(expRow), 32'($sampled(cma)));

    // Two clocks from tsN sampled to RAS
    rasAfterTs: assert property (@(posedge CLK40) disable iff (!RESETn)
        ($fell(rasN) && !dbenN && directRun) |-> $past(!tsN, 2))
        else reportValue("ras after ts", 32'd0, 32'($sampled($past(tsN, 2))));

    colAddress: assert property (@(posedge CLK40) disable iff (!RESETn)
        ($fell(casN) && !dbenN) |-> cma == expCol)
        else reportValue("column address", 32'(expCol), 32'($sampled(cma)));

    rasToCas: assert property (@(posedge CLK40) disable iff (!RESETn)
        ($fell(casN) && !dbenN) |-> ($past(rasN, RAS_TO_CAS + 1) && !$past(rasN, RAS_TO_CAS)))
        else reportValue("ras to cas", 32'd1, 32'($sampled($past(rasN, RAS_TO_CAS + 1))));

    casWidth: assert property (@(posedge CLK40) disable iff (!RESETn)
        ($rose(casN) && !dbenN) |-> ($past(casN, CAS_WIDTH + 1) && !$past(casN, CAS_WIDTH)))
        else reportValue("cas width", 32'd1, 32'($sampled($past(casN, CAS_WIDTH + 1))));

    // RAS and CAS rise together
    precharge: assert property (@(posedge CLK40) disable iff (!RESETn)
        ($rose(casN) && !dbenN) |-> $rose(rasN))
        else reportValue("precharge", 32'd1, 32'($sampled(rasN)));

    writeEnable: assert property (@(posedge CLK40) disable iff (!RESETn)
        !dbenN |-> weN == !(expWrite && !casN))
        else reportValue("write enable", 32'(!(expWrite && !casN)), 32'($sampled(weN)));

    ramAck: assert property (@(posedge CLK40) disable iff (!RESETn)
        ($rose(casN) && !dbenN) |=> !tackN)
        else reportValue("ram tack", 32'd0, 32'($sampled(tackN)));

    asPhase: assert property (@(posedge CLK40) disable iff (!RESETn)
        $fell(asN) |-> ($past(c1) && !$past(c3)))
        else reportValue("as phase", 32'b10, 32'($sampled({$past(c1), $past(c3)})));

    asHold: assert property (@(posedge CLK40) disable iff (!RESETn)
        $rose(asN) |-> ($past(asN, REG_HOLD + 1) && !$past(asN, REG_HOLD)))
        else reportValue("as hold", 32'd1, 32'($sampled($past(asN, REG_HOLD + 1))));

    // Register enable low with AS, data strobes by half
    dataStrobes: assert property (@(posedge CLK40) disable iff (!RESETn)
        !asN |-> {regEnN, udsN, ldsN} == {1'b0, ~strobeMask(expLane, expA1)})
        else reportValue("data strobes", 32'({1'b0, ~strobeMask(expLane, expA1)}),
            32'($sampled({regEnN, udsN, ldsN})));

    strobesIdle: assert property (@(posedge CLK40) disable iff (!RESETn)
        asN |-> (udsN && ldsN && regEnN))
        else reportValue("idle strobes", 32'b111, 32'($sampled({udsN, ldsN, regEnN})));

    regAck: assert property (@(posedge CLK40) disable iff (!RESETn)
        $rose(asN) |=> !tackN)
        else reportValue("register tack", 32'd0, 32'($sampled(tackN)));

    // Pins follow the chipset once the request is through the synchronizer
    dmaPassThrough: assert property (@(posedge CLK40) disable iff (!RESETn)
        (!dbrN && !$past(dbrN, 1) && !$past(dbrN, 2) && !$past(dbrN, 3))
        |-> dmaActual == dmaExpect)
        else reportValue("dma pass-through", 32'($sampled(dmaExpect)),
            32'($sampled(dmaActual)));

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic startTransfer(input logic ramSel, input logic regSel, input logic write,
                                 input logic [1:0] s, input logic [20:0] addr);
        @(posedge CLK40);
        tsN       <= 1'b0;
        rnw       <= !write;
        ramSpaceN <= !ramSel;
        regSpaceN <= !regSel;
        siz       <= s;
        a         <= addr;
        expLane   <= laneMask(s, addr[1:0]);
        expRow    <= addr[20:10];
        expCol    <= {3'b000, addr[9:2]};
        expWrite  <= write;
        expA1     <= addr[1];
        @(posedge CLK40);
        tsN       <= 1'b1;
        ramSpaceN <= 1'b1;
        regSpaceN <= 1'b1;
    endtask

    // Looks at tackN away from the active edge
    task automatic awaitAck(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < limit) begin
            @(negedge CLK40);
            seen = !tackN;
            n++;
        end
    endtask

    task automatic runCycle(input logic ramSel, input logic write, input logic [1:0] s,
                            input logic [20:0] addr, input string testName);
        logic seen;
        startTransfer(ramSel, !ramSel, write, s, addr);
        awaitAck(ACK_LIMIT, seen);
        if (!seen) begin
            otherErrors++;
            $display("%s: no tackN within %0d clocks", testName, ACK_LIMIT);
        end
    endtask

    // Random chipset strobes and row/column address
    task automatic dmaTraffic(input int n);
        logic [31:0] rnd;
        repeat (n) begin
            @(posedge CLK40);
            rnd = $random(seed);
            ras0N <= rnd[0];
            casLN <= rnd[1];
            casUN <= rnd[2];
            aweN  <= rnd[3];
            dra   <= rnd[13:4];
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] addrRnd;
        logic        seen;
        int          i;
        RESETn    = 1'b0;
        tsN       = 1'b1;
        rnw       = 1'b1;
        ramSpaceN = 1'b1;
        regSpaceN = 1'b1;
        siz       = 2'b00;
        a         = '0;
        dbrN      = 1'b1;
        ras0N     = 1'b1;
        casLN     = 1'b1;
        casUN     = 1'b1;
        aweN      = 1'b1;
        dra       = '0;
        expLane   = '0;
        expRow    = '0;
        expCol    = '0;
        expWrite  = 1'b0;
        expA1     = 1'b0;
        directRun = 1'b1;
        repeat (4) @(posedge CLK40);
        RESETn <= 1'b1;
        repeat (3) @(posedge CLK40);

        // Every size and alignment for RAM then register cycles
        for (i = 0; i < 16; i++) begin
            rnd = $random(seed);
            runCycle(1'b1, rnd[31], i[3:2], {rnd[20:2], i[1:0]}, "ram cycle");
        end
        for (i = 0; i < 16; i++) begin
            rnd = $random(seed);
            runCycle(1'b0, rnd[31], i[3:2], {rnd[20:2], i[1:0]}, "register cycle");
        end

        // Mixed random traffic
        for (i = 0; i < 16; i++) begin
            rnd     = $random(seed);
            addrRnd = $random(seed);
            runCycle(rnd[30], rnd[31], rnd[1:0], addrRnd[20:0], "random cycle");
        end

        // RAM cycle held off while DMA owns the DRAM
        @(posedge CLK40);
        dbrN      <= 1'b0;
        directRun <= 1'b0;
        dmaTraffic(12);
        addrRnd = $random(seed);
        startTransfer(1'b1, 1'b0, 1'b1, 2'b00, addrRnd[20:0]);
        dmaTraffic(8);
        @(posedge CLK40);
        dbrN  <= 1'b1;
        ras0N <= 1'b1;
        casLN <= 1'b1;
        casUN <= 1'b1;
        aweN  <= 1'b1;
        awaitAck(ACK_LIMIT, seen);
        if (!seen) begin
            otherErrors++;
            $display("DMA: RAM cycle held by DMA was never acknowledged");
        end
        @(posedge CLK40);
        directRun <= 1'b1;

        // No acknowledge expected with neither space selected
        rnd = $random(seed);
        startTransfer(1'b0, 1'b0, rnd[31], rnd[1:0], rnd[22:2]);
        awaitAck(ACK_LIMIT, seen);
        if (seen) begin
            otherErrors++;
            $display("No space: tackN answered a cycle with no space selected");
        end
        runCycle(1'b1, 1'b0, 2'b10, 21'h0a5a4, "ram after idle");

        repeat (4) @(posedge CLK40);
        $display("Errors: %0d value, %0d timeout or protocol", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        repeat (20000) @(posedge CLK40);
        $display("Simulation ran past its clock limit without finishing");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/cpuBusPkg.sv
hw/cycleDecode.sv
hw/chipRamCycle.sv
hw/regCycle.sv
hw/busResult.sv
hw/u712Bridge.sv
verif/u712BridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal --top-module u712BridgeTb -f verilog.f \
    && ./obj_dir/Vu712BridgeTb | tee "$LOG" \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q "Verification failed" "$LOG" && exit 1
grep -q "Verification passed" "$LOG" || exit 1
exit 0
